// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_tagv.sv
      - source/icache_data.sv
      - source/icache_refill.sv
      - source/icache_plru.sv
      - source/icache_ctrl.sv
      - source/icache.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clk_gen.sv
      - dv/icache_tb.sv

// ==== dv/icache_tb.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_tb import icache_pkg::*; ();

    localparam word_t MEM_PATTERN  = 32'h5A3C_96E1;
    localparam int    HIT_FETCHES  = 8;
    localparam int    REPL_LINES   = 5;
    localparam int    BP_FETCHES   = 4;
    localparam int    RAND_FETCHES = 300;
    localparam int    NUM_FETCHES  = 1 + HIT_FETCHES + 2 * REPL_LINES + BP_FETCHES + 2
                                     + RAND_FETCHES;
    localparam int    CYCLE_LIMIT  = 40 * NUM_FETCHES;

    logic   clk;
    logic   por_rst;
    logic   rst_force;
    logic   rst;
    logic   valid;
    addr_t  pc_in;
    addr_t  pc_next_in;
    logic   data_valid;
    fetch_t r_data;
    addr_t  pc_out;
    addr_t  pc_next_out;
    logic   r_req;
    logic   r_data_ready;
    addr_t  r_addr;
    logic   r_rdy;
    logic   ret_valid;
    logic   ret_last;
    word_t  r_data_axi;

    int     seed = 92111;
    int     gap_max = 1;       // widest gap between refill beats
    int     cycle_count = 0;
    int     check_count = 0;
    int     error_count = 0;
    int     test_errors = 0;
    int     test_fetches = 0;
    int     test_count = 0;
    int     fetch_count = 0;
    int     req_count = 0;     // accepted r_req
    int     model_misses = 0;
    int     issue_cycle;
    int     resp_latency;
    addr_t  req_addr;
    logic   pending = 1'b0;    // fetch waiting for data_valid
    fetch_t exp_data;
    addr_t  exp_pc;
    addr_t  exp_pc_next;
    string  cur_name = "";

    // reference cache state
    tag_t   ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic   ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
    plru_t  ref_tree  [`ICACHE_SETS];

    assign rst = por_rst | rst_force;

    tb_clk_gen #(.PERIOD(100.0), .RST_CYCLES(3)) u_clk_gen (
        .clk (clk),
        .rst (por_rst)
    );

    icache UUT (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .pc_in        (pc_in),
        .pc_next_in   (pc_next_in),
        .data_valid   (data_valid),
        .r_data       (r_data),
        .pc_out       (pc_out),
        .pc_next_out  (pc_next_out),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .r_addr       (r_addr),
        .r_rdy        (r_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .r_data_axi   (r_data_axi)
    );

    function automatic word_t mem_word(input addr_t a);
        word_t x;
        x = a ^ MEM_PATTERN;
        return {x[24:0], x[31:25]}; // rotate left by 7
    endfunction

    // instruction pair at the aligned doubleword holding pc
    function automatic fetch_t expected_fetch(input addr_t pc);
        addr_t base;
        base = {pc[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    function automatic void model_reset();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
    endfunction

    function automatic int pick_victim(input index_t idx);
        int v;
        v = -1;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!ref_valid[idx][w]) begin
                v = w;
            end
        end
        if (v < 0) begin // all ways valid so the tree decides
            if (ref_tree[idx][0]) begin
                v = ref_tree[idx][2] ? 3 : 2;
            end else begin
                v = ref_tree[idx][1] ? 1 : 0;
            end
        end
        return v;
    endfunction

    // returns 1 on a predicted hit and updates tags and tree
    function automatic logic model_access(input addr_t pc);
        index_t idx;
        tag_t   tg;
        int     way;
        logic   found;
        idx   = pc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        tg    = pc[31 -: `ICACHE_TAG_BITS];
        found = 1'b0;
        way   = 0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
                found = 1'b1;
                way   = w;
            end
        end
        if (!found) begin
            way = pick_victim(idx);
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = tg;
            model_misses++;
        end
        ref_tree[idx][0] = (way < 2);     // point at the other pair
        if (way < 2) begin
            ref_tree[idx][1] = (way == 0);
        end else begin
            ref_tree[idx][2] = (way == 2);
        end
        return found;
    endfunction

    task automatic compare_values(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic begin_test();
        test_errors  = 0;
        test_fetches = 0;
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %-16s %3d fetches, %0d errors", name, test_fetches, test_errors);
    endtask

    // issue one fetch at 1 ns after an edge and hold it until data_valid is seen
    task automatic run_fetch(input addr_t pc, input string name);
        logic exp_hit;
        int   req_before;
        exp_hit     = model_access(pc);
        exp_data    = expected_fetch(pc);
        exp_pc      = pc;
        exp_pc_next = pc + 32'd8;
        cur_name    = name;
        req_before  = req_count;
        issue_cycle = cycle_count;
        pending     = 1'b1;
        valid       = 1'b1;
        pc_in       = pc;
        pc_next_in  = pc + 32'd8;
        while (pending) begin
            @(posedge clk);
            #1;
        end
        valid = 1'b0;
        compare_values({name, " r_req count"}, exp_hit ? 0 : 1, req_count - req_before);
        if (exp_hit) begin
            compare_values({name, " hit latency"}, 1, resp_latency);
        end else begin
            compare_values({name, " r_addr"}, {pc[31:6], 6'b0}, req_addr);
        end
        fetch_count++;
        test_fetches++;
    endtask

    task automatic apply_reset();
        rst_force = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst_force = 1'b0;
        model_reset();
    endtask

    function automatic addr_t line_addr(input logic [5:0] k);
        // eight sets with eight tags each to force evictions in the random run
        return 32'h0002_0000 + (addr_t'(k[5:3]) << 10) + (addr_t'(k[2:0]) << 6);
    endfunction

    // compares at the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        if (data_valid === 1'b1) begin
            if (!pending) begin
                error_count++;
                $display("data_valid seen with no fetch outstanding at cycle %0d", cycle_count);
            end else begin
                compare_values({cur_name, " data"}, exp_data, r_data);
                compare_values({cur_name, " pc_out"}, exp_pc, pc_out);
                compare_values({cur_name, " pc_next_out"}, exp_pc_next, pc_next_out);
                resp_latency = cycle_count - issue_cycle;
                pending      = 1'b0;
            end
        end
    end

    initial begin : memory_model
        int    delay;
        int    gap;
        addr_t base;
        r_rdy      = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        r_data_axi = '0;
        forever begin
            @(posedge clk);
            #1;
            if (r_req === 1'b1) begin
                base  = r_addr;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                    if (r_req !== 1'b1 || r_addr !== base) begin
                        error_count++;
                        $display("r_req dropped or r_addr moved before r_rdy, base %h", base);
                    end
                end
                r_rdy = 1'b1;
                @(posedge clk);
                #1;
                r_rdy    = 1'b0;
                req_count++;
                req_addr = base;
                for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
                    gap = $unsigned($random(seed)) % (gap_max + 1);
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    compare_values("refill r_data_ready", 1, r_data_ready);
                    ret_valid  = 1'b1;
                    ret_last   = (i == `ICACHE_LINE_WORDS - 1);
                    r_data_axi = mem_word(base + 32'(4 * i));
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: no finish within %0d cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        logic [5:0] k;
        int         w;
        int         miss_before;
        int         req_before;
        valid      = 1'b0;
        pc_in      = '0;
        pc_next_in = '0;
        rst_force  = 1'b0;
        model_reset();
        wait (por_rst === 1'b0);
        @(posedge clk);
        #1;

        begin_test();
        run_fetch(32'h0000_1A4C, "cold_miss");
        report_test("cold_miss");

        begin_test();
        for (int i = 0; i < HIT_FETCHES; i++) begin
            run_fetch(32'h0000_1A40 + 32'(8 * i + (i % 2) * 4), "hit");
        end
        report_test("hit");

        begin_test(); // all five lines land in set 3
        for (int t = 1; t <= REPL_LINES; t++) begin
            run_fetch((32'(t) << 10) | (32'd3 << 6), "replace_fill");
        end
        for (int t = 1; t <= REPL_LINES; t++) begin
            run_fetch(((32'(t) << 10) | (32'd3 << 6)) + 32'd8, "replace_refetch");
        end
        report_test("replacement");

        begin_test();
        gap_max = 3;
        for (int i = 0; i < BP_FETCHES; i++) begin
            run_fetch(32'h0004_0000 + 32'(64 * i + 12), "backpressure");
        end
        gap_max = 1;
        report_test("backpressure");

        begin_test();
        run_fetch(32'h0000_1A48, "reset_warm");
        apply_reset();
        run_fetch(32'h0000_1A48, "reset_cold");
        report_test("reset");

        begin_test();
        miss_before = model_misses;
        req_before  = req_count;
        for (int n = 0; n < RAND_FETCHES; n++) begin
            k = $unsigned($random(seed)) % 64;
            w = $unsigned($random(seed)) % `ICACHE_LINE_WORDS;
            run_fetch(line_addr(k) + 32'(4 * w), "random");
        end
        compare_values("random miss count", model_misses - miss_before, req_count - req_before);
        report_test("random");

        $display("%0d tests, %0d fetches, %0d checks, %0d errors",
                 test_count, fetch_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD     = 100.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // power-on reset released just after an edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== list.f ====
+incdir+source
source/icache_pkg.sv
source/icache_tagv.sv
source/icache_data.sv
source/icache_refill.sv
source/icache_plru.sv
source/icache_ctrl.sv
source/icache.sv
dv/tb_clk_gen.sv
dv/icache_tb.sv

// ==== source/icache.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   valid,
    input  addr_t  pc_in,
    input  addr_t  pc_next_in,
    output logic   data_valid,
    output fetch_t r_data,
    output addr_t  pc_out,
    output addr_t  pc_next_out,
    output logic   r_req,
    output logic   r_data_ready,
    output addr_t  r_addr,
    input  logic   r_rdy,
    input  logic   ret_valid,
    input  logic   ret_last,
    input  word_t  r_data_axi
);

    addr_t                     pc_buf;
    addr_t                     pc_next_buf;
    way_mask_t                 victim;
    way_mask_t                 victim_buf;
    way_mask_t                 hit;
    way_mask_t                 valid_ways;
    way_mask_t                 tagv_we;
    way_mask_t                 data_we;
    way_mask_t                 touch;
    fetch_t [`ICACHE_WAYS-1:0] way_dout;
    fetch_t                    hit_dout;
    line_t                     line;
    index_t                    buf_index;
    logic [2:0]                buf_dw;
    logic                      cache_hit;
    logic                      line_done;
    logic                      refill_end;
    logic                      rbuf_we;
    logic                      vbuf_we;
    logic                      plru_en;
    logic                      refill_start;
    logic                      rdata_sel;

    // request buffer
    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            pc_buf      <= pc_in;
            pc_next_buf <= pc_next_in;
        end
    end

    // victim buffer latched on the miss
    always_ff @(posedge clk) begin
        if (vbuf_we) begin
            victim_buf <= victim;
        end
    end

    assign buf_index   = pc_buf[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign buf_dw      = pc_buf[`ICACHE_OFFSET_BITS-1:3];
    assign r_addr      = {pc_buf[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
    assign pc_out      = pc_buf;
    assign pc_next_out = pc_next_buf;
    assign touch       = (|tagv_we) ? tagv_we : hit; // fill way or hit way
    assign refill_end  = line_done || (ret_valid && ret_last);

    always_comb begin
        hit_dout = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit[w]) begin
                hit_dout |= way_dout[w];
            end
        end
    end

    assign r_data = rdata_sel ? line[buf_dw*64 +: 64] : hit_dout;

    icache_tagv u_tagv (
        .clk        (clk),
        .rst        (rst),
        .r_addr     (pc_in),
        .w_addr     (pc_buf),
        .we         (tagv_we),
        .hit        (hit),
        .valid_ways (valid_ways),
        .cache_hit  (cache_hit)
    );

    icache_data u_data (
        .clk    (clk),
        .r_addr (pc_in),
        .w_addr (pc_buf),
        .din    (line),
        .we     (data_we),
        .dout   (way_dout)
    );

    icache_refill u_refill (
        .clk       (clk),
        .rst       (rst),
        .start     (refill_start),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .r_data    (r_data_axi),
        .line      (line),
        .line_done (line_done)
    );

    icache_plru u_plru (
        .clk        (clk),
        .rst        (rst),
        .en         (plru_en),
        .index      (buf_index),
        .touch      (touch),
        .valid_ways (valid_ways),
        .victim     (victim)
    );

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .cache_hit    (cache_hit),
        .r_rdy        (r_rdy),
        .line_done    (refill_end),
        .victim_way   (victim_buf),
        .rbuf_we      (rbuf_we),
        .vbuf_we      (vbuf_we),
        .plru_en      (plru_en),
        .refill_start (refill_start),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .rdata_sel    (rdata_sel),
        .data_valid   (data_valid),
        .tagv_we      (tagv_we),
        .data_we      (data_we)
    );

endmodule

// ==== source/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// line geometry
`define ICACHE_LINE_WORDS  16 // 64 bytes per line
`define ICACHE_SETS        16
`define ICACHE_WAYS        4

// address split into tag, index and offset
`define ICACHE_OFFSET_BITS 6  // pc[5:0]
`define ICACHE_INDEX_BITS  4  // pc[9:6]
`define ICACHE_TAG_BITS    22 // pc[31:10]

`endif

// ==== source/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      valid,
    input  logic      cache_hit,
    input  logic      r_rdy,
    input  logic      line_done,
    input  way_mask_t victim_way,
    output logic      rbuf_we,
    output logic      vbuf_we,
    output logic      plru_en,
    output logic      refill_start,
    output logic      r_req,
    output logic      r_data_ready,
    output logic      rdata_sel,
    output logic      data_valid,
    output way_mask_t tagv_we,
    output way_mask_t data_we
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (valid) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP:   state_next = cache_hit ? ST_IDLE : ST_MISS_REQ;
            ST_MISS_REQ: begin
                if (r_rdy) begin
                    state_next = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (line_done) begin // last beat sampled
                    state_next = ST_FILL;
                end
            end
            ST_FILL:     state_next = ST_RESP;
            ST_RESP:     state_next = ST_IDLE;
            default:     state_next = ST_IDLE;
        endcase
    end

    assign rbuf_we      = (state == ST_IDLE) && valid;        // request accepted
    assign vbuf_we      = (state == ST_LOOKUP) && !cache_hit; // miss detected
    assign plru_en      = ((state == ST_LOOKUP) && cache_hit) || (state == ST_FILL);
    assign refill_start = (state == ST_MISS_REQ) && r_rdy;
    assign r_req        = (state == ST_MISS_REQ);
    assign r_data_ready = (state == ST_REFILL);
    assign rdata_sel    = (state == ST_RESP);                 // answer from refill line
    assign data_valid   = ((state == ST_LOOKUP) && cache_hit) || (state == ST_RESP);
    assign tagv_we      = (state == ST_FILL) ? victim_way : '0;
    assign data_we      = (state == ST_FILL) ? victim_way : '0;

    // the memory side answers only a pending request
    a_rdy_with_req: assert property (@(posedge clk) disable iff (rst) r_rdy |-> r_req);

    a_dv_pulse: assert property (@(posedge clk) disable iff (rst)
        data_valid |=> !data_valid);

endmodule

// ==== source/icache_data.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_data import icache_pkg::*; (
    input  logic                        clk,
    input  addr_t                       r_addr,
    input  addr_t                       w_addr,
    input  line_t                       din,
    input  way_mask_t                   we,
    output fetch_t [`ICACHE_WAYS-1:0]   dout
);

    localparam int DW_BITS = `ICACHE_OFFSET_BITS - 3; // doublewords per line select

    line_t              mem [`ICACHE_WAYS][`ICACHE_SETS];
    index_t             r_index;
    index_t             w_index;
    logic [DW_BITS-1:0] r_dw;

    assign r_index = r_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign w_index = w_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign r_dw    = r_addr[`ICACHE_OFFSET_BITS-1:3];

    // whole line written into the selected way
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (we[w]) begin
                mem[w][w_index] <= din;
            end
        end
    end

    // every way reads its doubleword for the hit mux in the top level
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            dout[w] <= mem[w][r_index][r_dw*64 +: 64];
        end
    end

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

`include "icache_consts.svh"

    typedef logic [31:0] addr_t;  // byte address
    typedef logic [31:0] word_t;  // instruction or refill beat
    typedef logic [63:0] fetch_t; // low word at lower address

    typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t; // word 0 in low bits
    typedef logic [`ICACHE_TAG_BITS-1:0]      tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0]    index_t;
    typedef logic [`ICACHE_WAYS-1:0]          way_mask_t;
    typedef logic [2:0]                       plru_t; // tree bits of one set

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS_REQ,
        ST_REFILL,
        ST_FILL,
        ST_RESP
    } ctrl_state_t;

endpackage

// ==== source/icache_plru.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_plru import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      en,
    input  index_t    index,
    input  way_mask_t touch,
    input  way_mask_t valid_ways,
    output way_mask_t victim
);

    plru_t     tree_q [`ICACHE_SETS];
    plru_t     tree;
    plru_t     tree_upd;
    way_mask_t tree_way;

    assign tree = tree_q[index];

    // bit 0 picks the pair and bits 1 and 2 the way inside it
    assign tree_way = tree[0] ? (tree[2] ? 4'b1000 : 4'b0100)
                              : (tree[1] ? 4'b0010 : 4'b0001);

    always_comb begin
        victim = tree_way;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin // lowest invalid way wins
            if (!valid_ways[w]) begin
                victim    = '0;
                victim[w] = 1'b1;
            end
        end
    end

    // point the touched path away from the touched way
    always_comb begin
        tree_upd = tree;
        if (touch[0]) begin
            tree_upd[0] = 1'b1;
            tree_upd[1] = 1'b1;
        end else if (touch[1]) begin
            tree_upd[0] = 1'b1;
            tree_upd[1] = 1'b0;
        end else if (touch[2]) begin
            tree_upd[0] = 1'b0;
            tree_upd[2] = 1'b1;
        end else if (touch[3]) begin
            tree_upd[0] = 1'b0;
            tree_upd[2] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (en) begin
            tree_q[index] <= tree_upd;
        end
    end

    // update comes from a hit or a fill of a single way
    a_touch_onehot: assert property (@(posedge clk) disable iff (rst) en |-> $onehot(touch));

endmodule

// ==== source/icache_refill.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_refill import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  ret_valid,
    input  logic  ret_last,
    input  word_t r_data,
    output line_t line,
    output logic  line_done
);

    localparam int CNT_BITS = $clog2(`ICACHE_LINE_WORDS);
    localparam logic [CNT_BITS-1:0] LAST_BEAT = CNT_BITS'(`ICACHE_LINE_WORDS - 1);

    logic [CNT_BITS-1:0] beat_cnt; // next word position

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt  <= '0;
            line_done <= 1'b0;
        end else if (start) begin // r_req accepted
            beat_cnt  <= '0;
            line_done <= 1'b0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (ret_last) begin
                line_done <= 1'b1; // held until the next miss
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            line[beat_cnt*32 +: 32] <= r_data;
        end
    end

    a_no_beat_after_done: assert property (@(posedge clk) disable iff (rst)
        line_done |-> !ret_valid);

    a_last_on_16th: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (ret_last == (beat_cnt == LAST_BEAT)));

endmodule

// ==== source/icache_tagv.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_tagv import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  addr_t     r_addr,
    input  addr_t     w_addr,
    input  way_mask_t we,
    output way_mask_t hit,
    output way_mask_t valid_ways,
    output logic      cache_hit
);

    tag_t      tag_q   [`ICACHE_WAYS][`ICACHE_SETS];
    way_mask_t valid_q [`ICACHE_SETS];
    index_t    look_index;
    tag_t      look_tag;
    index_t    w_index;
    tag_t      w_tag;

    assign w_index = w_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign w_tag   = w_addr[31 -: `ICACHE_TAG_BITS];

    // lookup address compared one cycle later
    always_ff @(posedge clk) begin
        look_index <= r_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        look_tag   <= r_addr[31 -: `ICACHE_TAG_BITS];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    tag_q[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (we[w]) begin
                    valid_q[w_index][w] <= 1'b1;
                    tag_q[w][w_index]   <= w_tag;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit[w] = valid_q[look_index][w] && (tag_q[w][look_index] == look_tag);
        end
    end

    assign valid_ways = valid_q[look_index]; // feeds victim choice
    assign cache_hit  = |hit;

    // a filled tag never lands in two ways of one set
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit));

endmodule
